// ==== compile.f ====
+incdir+logic
logic/fft_pkg.sv
logic/twiddle_rom.sv
logic/butterfly.sv
logic/delay_commutator.sv
logic/output_reorder.sv
logic/fft_pipeline.sv
test/fft_tb.sv

// ==== logic/butterfly.sv ====
// one radix-2 DIF butterfly stage with its own twiddle sequence, used once per pipeline stage
`timescale 1ns/10ps
`include "fft_defs.svh"

module butterfly
    import fft_pkg::*;
#(
    parameter int STAGE = 0 // 0 is the first stage
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    input  cpair_t in_pair,
    output logic   out_valid,
    output cpair_t out_pair
);

    localparam int CNT_W = $clog2(`FFT_N/2);
    // pairs sharing one twiddle period at this stage
    localparam int SPAN = (`FFT_N/2) >> STAGE;

    logic [CNT_W-1:0] pair_cnt; // m within the frame
    logic [CNT_W-1:0] exp_in;   // twiddle exponent for the incoming pair

    // first register, sum and difference
    logic signed [`DATA_W:0] sum_re;
    logic signed [`DATA_W:0] sum_im;
    logic signed [`DATA_W:0] diff_re;
    logic signed [`DATA_W:0] diff_im;
    complex_t                sum_q;
    logic signed [`DATA_W:0] diff_re_q;
    logic signed [`DATA_W:0] diff_im_q;
    logic [CNT_W-1:0]        exp_q;
    logic                    v1_q;

    // second stage, twiddle product
    complex_t                          tw;
    logic signed [`COEFF_W-1:0]        tw_re;
    logic signed [`COEFF_W-1:0]        tw_im;
    logic signed [`DATA_W+`COEFF_W:0]  prod_re; // 17x16 products plus one carry
    logic signed [`DATA_W+`COEFF_W:0]  prod_im;

    // exponent is (m mod SPAN) * 2^STAGE
    assign exp_in = (pair_cnt & CNT_W'(SPAN - 1)) << STAGE;

    assign sum_re  = in_pair.a.re + in_pair.b.re; // one bit growth
    assign sum_im  = in_pair.a.im + in_pair.b.im;
    assign diff_re = in_pair.a.re - in_pair.b.re;
    assign diff_im = in_pair.a.im - in_pair.b.im;

    always_ff @(posedge clk) begin
        if (rst) begin
            pair_cnt <= '0;
            v1_q     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (in_valid) begin
                pair_cnt <= pair_cnt + 1'b1; // wraps at a frame boundary
            end
            v1_q      <= in_valid;
            out_valid <= v1_q;
        end
    end

    // halving by dropping the lsb floors toward minus infinity
    always_ff @(posedge clk) begin
        sum_q.re  <= sum_re[`DATA_W:1];
        sum_q.im  <= sum_im[`DATA_W:1];
        diff_re_q <= diff_re;
        diff_im_q <= diff_im;
        exp_q     <= exp_in;
    end

    twiddle_rom i_twiddle_rom (
        .exponent (exp_q),
        .w        (tw)
    );

    assign tw_re = `COEFF_W'(tw.re);
    assign tw_im = `COEFF_W'(tw.im);

    // (dr + j di)(wr + j wi)
    assign prod_re = diff_re_q * tw_re - diff_im_q * tw_im;
    assign prod_im = diff_re_q * tw_im + diff_im_q * tw_re;

    always_ff @(posedge clk) begin
        out_pair.a    <= sum_q; // sum waits one cycle for the product
        out_pair.b.re <= prod_re[`COEFF_FRAC+`DATA_W:`COEFF_FRAC+1]; // >>> 15
        out_pair.b.im <= prod_im[`COEFF_FRAC+`DATA_W:`COEFF_FRAC+1];
    end

endmodule

// ==== logic/delay_commutator.sv ====
// delay-and-swap stage that re-pairs butterfly outputs for the next DIF stage
`timescale 1ns/10ps
`include "fft_defs.svh"

module delay_commutator
    import fft_pkg::*;
#(
    parameter int DELAY = 2 // pairs per switch phase, power of two
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    input  cpair_t in_pair,
    output logic   out_valid,
    output cpair_t out_pair
);

    localparam int PH_W = $clog2(2 * DELAY);

    complex_t [DELAY-1:0] b_dly;  // lower lane ahead of the switch
    complex_t [DELAY-1:0] a_dly;  // upper output lane behind the switch
    logic     [DELAY-1:0] v_dly;  // valid follows the lower lane
    logic     [PH_W-1:0]  phase_cnt;
    logic                 swap;
    complex_t             b_late; // lower input DELAY cycles old
    complex_t             to_dly; // switch output into the upper delay
    complex_t             direct; // switch output straight to lane b

    assign swap   = phase_cnt[PH_W-1]; // second half of each 2*DELAY block
    assign b_late = b_dly[DELAY-1];

    // phase 0 sends fresh a into the delay, phase 1 sends the old b
    always_comb begin
        if (swap) begin
            to_dly = b_late;
            direct = in_pair.a;
        end else begin
            to_dly = in_pair.a;
            direct = b_late;
        end
    end

    // control, counts only real samples so gaps keep the phase
    always_ff @(posedge clk) begin
        if (rst) begin
            phase_cnt <= '0;
            v_dly     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (in_valid) begin
                phase_cnt <= phase_cnt + 1'b1;
            end
            v_dly[0] <= in_valid;
            for (int i = 1; i < DELAY; i++) begin
                v_dly[i] <= v_dly[i-1];
            end
            out_valid <= v_dly[DELAY-1];
        end
    end

    // both lines shift every cycle
    always_ff @(posedge clk) begin
        b_dly[0] <= in_pair.b;
        a_dly[0] <= to_dly;
        for (int i = 1; i < DELAY; i++) begin
            b_dly[i] <= b_dly[i-1];
            a_dly[i] <= a_dly[i-1];
        end
        out_pair.a <= a_dly[DELAY-1];
        out_pair.b <= direct;
    end

endmodule

// ==== logic/fft_defs.svh ====
// transform size and word widths for the 8-point FFT pipeline, included by package and RTL
`ifndef FFT_DEFS_SVH
`define FFT_DEFS_SVH

// points per transform
`define FFT_N 8

// signed width of each real and imaginary part
`define DATA_W 16

// twiddle coefficient width, signed Q1.14
`define COEFF_W 16

// fraction bits of a twiddle coefficient
`define COEFF_FRAC 14

`endif

// ==== logic/fft_pipeline.sv ====
// top of the streaming 8-point MDC FFT, takes sample pairs and emits whole frames
`timescale 1ns/10ps
`include "fft_defs.svh"

module fft_pipeline
    import fft_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid, // four contiguous cycles per frame
    input  cpair_t in_pair,  // sample m on a, m+N/2 on b
    output logic   out_valid,
    output frame_t out_frame
);

    localparam int STAGES = $clog2(`FFT_N);

    // butterfly outputs
    wire [STAGES-1:0]         bf_valid;
    wire cpair_t [STAGES-1:0] bf_pair;

    // commutator outputs, feeding stages 1 and up
    wire [STAGES-2:0]         dc_valid;
    wire cpair_t [STAGES-2:0] dc_pair;

    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        logic   st_valid; // this stage's input
        cpair_t st_pair;

        if (s == 0) begin : g_first
            assign st_valid = in_valid;
            assign st_pair  = in_pair;
        end else begin : g_next
            assign st_valid = dc_valid[s-1];
            assign st_pair  = dc_pair[s-1];
        end

        butterfly #(
            .STAGE (s)
        ) i_butterfly (
            .clk       (clk),
            .rst       (rst),
            .in_valid  (st_valid),
            .in_pair   (st_pair),
            .out_valid (bf_valid[s]),
            .out_pair  (bf_pair[s])
        );

        // halving delay each stage, 2 then 1 for N=8
        if (s < STAGES - 1) begin : g_dc
            delay_commutator #(
                .DELAY (`FFT_N >> (s + 2))
            ) i_delay_commutator (
                .clk       (clk),
                .rst       (rst),
                .in_valid  (bf_valid[s]),
                .in_pair   (bf_pair[s]),
                .out_valid (dc_valid[s]),
                .out_pair  (dc_pair[s])
            );
        end
    end

    // last stage leaves bins in bit-reversed order
    output_reorder i_output_reorder (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (bf_valid[STAGES-1]),
        .in_pair   (bf_pair[STAGES-1]),
        .out_valid (out_valid),
        .out_frame (out_frame)
    );

endmodule

// ==== logic/fft_pkg.sv ====
// shared sample, pair and frame types for the FFT pipeline, imported by every stage
`include "fft_defs.svh"

package fft_pkg;

    // one complex sample
    typedef struct packed {
        logic signed [`DATA_W-1:0] re;
        logic signed [`DATA_W-1:0] im;
    } complex_t;

    // two samples travelling side by side on one path
    typedef struct packed {
        complex_t a; // upper lane
        complex_t b; // lower lane
    } cpair_t;

    // full transform result, element k is bin k
    typedef complex_t [`FFT_N-1:0] frame_t;

endpackage

// ==== logic/output_reorder.sv ====
// gathers the last stage's pairs into a natural order frame and presents it for one cycle
`timescale 1ns/10ps
`include "fft_defs.svh"

module output_reorder
    import fft_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    input  cpair_t in_pair,
    output logic   out_valid,
    output frame_t out_frame
);

    localparam int CNT_W = $clog2(`FFT_N/2);
    localparam int IDX_W = $clog2(`FFT_N);

    logic [CNT_W-1:0] pair_cnt; // j within the frame
    logic             last;     // fourth pair arriving
    logic [IDX_W-1:0] idx_a;    // DIF position 2j
    logic [IDX_W-1:0] idx_b;    // DIF position 2j+1
    frame_t           shadow;   // frame being filled
    frame_t           next_frame;

    function automatic logic [IDX_W-1:0] bit_rev(input logic [IDX_W-1:0] idx);
        logic [IDX_W-1:0] rev;
        for (int i = 0; i < IDX_W; i++) begin
            rev[i] = idx[IDX_W-1-i];
        end
        return rev;
    endfunction

    assign last  = (pair_cnt == CNT_W'(`FFT_N/2 - 1));
    assign idx_a = {pair_cnt, 1'b0};
    assign idx_b = {pair_cnt, 1'b1};

    // shadow with this pair dropped into its bins
    always_comb begin
        next_frame = shadow;
        next_frame[bit_rev(idx_a)] = in_pair.a;
        next_frame[bit_rev(idx_b)] = in_pair.b;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pair_cnt  <= '0;
            out_valid <= 1'b0;
        end else begin
            if (in_valid) begin
                pair_cnt <= pair_cnt + 1'b1;
            end
            out_valid <= in_valid && last; // one pulse per frame
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            shadow <= next_frame;
        end
        if (in_valid && last) begin
            out_frame <= next_frame; // held until the next frame completes
        end
    end

endmodule

// ==== logic/twiddle_rom.sv ====
// constant twiddle table, maps an exponent to Q1.14 cosine and negated sine for one butterfly
`timescale 1ns/10ps
`include "fft_defs.svh"

module twiddle_rom
    import fft_pkg::*;
(
    input  logic [$clog2(`FFT_N/2)-1:0] exponent, // k of W_N^k
    output complex_t                    w
);

    // unity in Q1.14
    localparam int ONE = 1 << `COEFF_FRAC;
    // cos(pi/4) scaled, 46341/65536 is sqrt(1/2)
    localparam int RT_HALF = (ONE * 46341) >> 16;

    logic signed [`COEFF_W-1:0] w_re; // cosine
    logic signed [`COEFF_W-1:0] w_im; // minus sine

    always_comb begin
        case (exponent)
            2'd0: begin
                w_re = `COEFF_W'(ONE);
                w_im = '0;
            end
            2'd1: begin // pi/4
                w_re = `COEFF_W'(RT_HALF);
                w_im = `COEFF_W'(-RT_HALF);
            end
            2'd2: begin // pi/2
                w_re = '0;
                w_im = `COEFF_W'(-ONE);
            end
            default: begin // 3pi/4
                w_re = `COEFF_W'(-RT_HALF);
                w_im = `COEFF_W'(-RT_HALF);
            end
        endcase
    end

    // sign extend into the sample format
    assign w.re = `DATA_W'(w_re);
    assign w.im = `DATA_W'(w_im);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the FFT testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module fft_tb -f compile.f -o fft_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/fft_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi

// ==== test/fft_stim.txt ====
# per frame: idle cycles before it, then samples 0..7 as re im pairs,
# then the expected bins 0..7 as re im pairs, all signed decimal
# frames: impulse, constant, bin 3 tone, two arbitrary, then repeats with gaps
3  803 -405  0 0  0 0  0 0
0 0  0 0  0 0  0 0
100 -51  100 -51  100 -51  100 -51
100 -51  100 -51  100 -51  100 -51
0  -1001 333  -1001 333  -1001 333  -1001 333
-1001 333  -1001 333  -1001 333  -1001 333
-1001 333  0 0  0 0  0 0
0 0  0 0  0 0  0 0
0  4096 0  -2896 2896  0 -4096  2896 2896
-4096 0  2896 -2896  0 4096  -2896 -2896
0 0  0 -1  0 0  4095 0
0 0  0 0  0 0  0 0
1  -32768 100  1000 -2000  3 5  -7 1234
-32768 -32768  -3000 500  17 -9  250 4321
-8410 -3578  -117 3830  -9077 -3803  -873 3723
-7970 -4591  119 4389  -7313 -4363  868 4489
5  -32768 0  0 -32768  32767 0  0 32767
0 0  0 0  0 0  0 0
-1 -1  -4097 -9889  -16384 0  -4096 9888
-1 0  -4096 1696  0 0  -4096 -1696
0  -32768 100  1000 -2000  3 5  -7 1234
-32768 -32768  -3000 500  17 -9  250 4321
-8410 -3578  -117 3830  -9077 -3803  -873 3723
-7970 -4591  119 4389  -7313 -4363  868 4489
2  803 -405  0 0  0 0  0 0
0 0  0 0  0 0  0 0
100 -51  100 -51  100 -51  100 -51
100 -51  100 -51  100 -51  100 -51
4  -32768 0  0 -32768  32767 0  0 32767
0 0  0 0  0 0  0 0
-1 -1  -4097 -9889  -16384 0  -4096 9888
-1 0  -4096 1696  0 0  -4096 -1696

// ==== test/fft_tb.sv ====
// testbench for the 8-point FFT pipeline, replays frames and expected bins from the stim file
`timescale 1ns/10ps
`include "fft_defs.svh"

module fft_tb
    import fft_pkg::*;
();

    localparam int REC_LEN = 1 + 4 * `FFT_N; // gap, 8 inputs, 8 bins, re and im each

    logic   clk = 1'b0;
    logic   rst;
    logic   in_valid;
    cpair_t in_pair;
    logic   out_valid;
    frame_t out_frame;

    bit     drv_valid[$]; // one entry per cycle
    cpair_t drv_pair[$];
    frame_t exp_q[$];     // frames still owed by the DUT
    int     nums[$];      // every number in the file
    int     n_frames = 0;
    int     frames_fed = 0;
    int     frames_out = 0;
    int     val_errors = 0;
    int     other_errors = 0;
    int     cycles = 0;
    int     cycle_limit = 50;
    int     pairs_in_frame = 0;
    bit     load_ok;

    fft_pipeline i_fft_pipeline (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_pair   (in_pair),
        .out_valid (out_valid),
        .out_frame (out_frame)
    );

    always #2 clk = ~clk; // 4 ns period

    // pull signed decimal numbers out of one text line
    task automatic parse_line(input string line);
        int  val;
        bit  neg;
        bit  in_num;
        byte c;
        val = 0;
        neg = 1'b0;
        in_num = 1'b0;
        for (int i = 0; i < line.len(); i++) begin
            c = line[i];
            if (c >= "0" && c <= "9") begin
                val = val * 10 + int'(c) - 48;
                in_num = 1'b1;
            end else begin
                if (in_num) begin
                    nums.push_back(neg ? -val : val);
                end
                neg = (c == "-"); // sign only counts right before digits
                val = 0;
                in_num = 1'b0;
            end
        end
        if (in_num) begin
            nums.push_back(neg ? -val : val);
        end
    endtask

    // build the per-cycle drive queue and the expected frames
    task automatic load_stim(output bit ok);
        int       fd;
        int       p;
        string    line;
        frame_t   exp_f;
        cpair_t   pr;
        complex_t x [`FFT_N];
        ok = 1'b0;
        fd = $fopen("test/fft_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file test/fft_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#") begin
                    parse_line(line);
                end
            end
            $fclose(fd);
            if (nums.size() == 0 || nums.size() % REC_LEN != 0) begin
                $display("stimulus file holds %0d numbers, not whole frame records", nums.size());
            end else begin
                n_frames = nums.size() / REC_LEN;
                p = 0;
                for (int f = 0; f < n_frames; f++) begin
                    repeat (nums[p]) begin // idle cycles ahead of the frame
                        drv_valid.push_back(1'b0);
                        drv_pair.push_back('0);
                    end
                    p++;
                    for (int n = 0; n < `FFT_N; n++) begin
                        x[n].re = `DATA_W'(nums[p]);
                        x[n].im = `DATA_W'(nums[p+1]);
                        p += 2;
                    end
                    for (int m = 0; m < `FFT_N/2; m++) begin
                        pr.a = x[m];          // sample m
                        pr.b = x[m+`FFT_N/2]; // sample m+4
                        drv_valid.push_back(1'b1);
                        drv_pair.push_back(pr);
                    end
                    for (int k = 0; k < `FFT_N; k++) begin
                        exp_f[k].re = `DATA_W'(nums[p]);
                        exp_f[k].im = `DATA_W'(nums[p+1]);
                        p += 2;
                    end
                    exp_q.push_back(exp_f);
                end
                cycle_limit = 20 * n_frames + 50;
                ok = 1'b1;
            end
        end
    endtask

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d frames came out",
                     cycles, frames_out, n_frames);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // outputs sampled mid cycle
    always @(negedge clk) begin
        frame_t exp_f;
        if (!rst && out_valid) begin
            assert (frames_out < frames_fed) else begin
                $display("out_valid rose before a frame had been fully supplied");
                other_errors++;
            end
            assert (exp_q.size() > 0) else begin
                $display("an extra frame came out with none left to expect");
                other_errors++;
            end
            if (exp_q.size() > 0) begin
                exp_f = exp_q.pop_front();
                for (int k = 0; k < `FFT_N; k++) begin
                    assert (out_frame[k] == exp_f[k]) else begin
                        $display("[ERROR] %0t ns frame %0d bin %0d want (%0d,%0d) got (%0d,%0d)",
                                 $time, frames_out, k, exp_f[k].re, exp_f[k].im,
                                 out_frame[k].re, out_frame[k].im);
                        val_errors++;
                    end
                end
            end
            frames_out++;
        end
    end

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        in_pair = '0;
        load_stim(load_ok);
        if (!load_ok) begin
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            repeat (4) @(posedge clk);
            rst <= 1'b0;
            for (int i = 0; i < drv_valid.size(); i++) begin
                @(posedge clk);
                in_valid <= drv_valid[i];
                in_pair  <= drv_pair[i];
                if (drv_valid[i]) begin
                    pairs_in_frame++;
                    if (pairs_in_frame == `FFT_N/2) begin // last pair of a frame
                        frames_fed++;
                        pairs_in_frame = 0;
                    end
                end
            end
            @(posedge clk);
            in_valid <= 1'b0;
            while (frames_out < n_frames) begin
                @(posedge clk);
            end
            repeat (20) @(posedge clk); // room for a stray extra frame
            assert (frames_out == n_frames) else begin
                $display("%0d frames came out where %0d were sent", frames_out, n_frames);
                other_errors++;
            end
            $display("frames in %0d out %0d, value errors %0d, other errors %0d",
                     frames_fed, frames_out, val_errors, other_errors);
            if (val_errors + other_errors == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule
